/* common/bus_pkg.sv */
// Shared bus definitions for the pipelined-to-flat bus bridge.
// Holds widths, the RAM window base and the request and response structs.

`default_nettype none

package bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus widths.
    // ~~~~~~~~~~~~~~~~~~~~

    // Byte address width.
    parameter int ADDR_W = 32;
    // Data word width.
    parameter int DATA_W = 32;
    // One byte enable per data byte.
    parameter int BE_W = DATA_W / 8;

    // First byte address of the RAM window.
    parameter logic [ADDR_W-1:0] RAM_BASE = 32'h0000_1000;

    // ~~~~~~~~~~~~~~~~~~~~
    // Request and response.
    // ~~~~~~~~~~~~~~~~~~~~

    // One request, used on the pipelined bus and on the flat bus.
    // Both strobes low means the request is idle.
    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   byte_en;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // Response to a request.
    // Busy high stretches the access, error and rdata are valid when it drops.
    typedef struct packed {
        logic              busy;
        logic              error;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* hdl/bus_addr_decode.sv */
// Address decode stage on the flat bus.
// Passes RAM window hits through, answers misses at once with error.

`timescale 1ns/1ps
`default_nettype none

module bus_addr_decode #(
    parameter int RAM_WORDS = 256
) (
    input  bus_pkg::bus_req_t flat_req,
    output bus_pkg::bus_rsp_t flat_rsp,
    output bus_pkg::bus_req_t ram_req,
    input  bus_pkg::bus_rsp_t ram_rsp
);

    import bus_pkg::*;

    // Size of the RAM window in bytes.
    localparam logic [ADDR_W-1:0] WIN_BYTES = ADDR_W'(BE_W * RAM_WORDS);

    // Byte offset into the window.
    logic [ADDR_W-1:0] win_off;
    // Request has a strobe set.
    logic active;
    // Address is aligned and inside the window.
    logic hit;
    // Active request outside the window.
    logic miss;

    // ~~~~~~~~~~~~~~~~~~~~
    // Window check.
    // ~~~~~~~~~~~~~~~~~~~~

    assign win_off = flat_req.addr - RAM_BASE;
    assign active  = flat_req.ren || flat_req.wen;

    // Lower bound, upper bound, word alignment.
    assign hit = (flat_req.addr >= RAM_BASE)
              && (win_off < WIN_BYTES)
              && (flat_req.addr[1:0] == 2'b00);

    assign miss = active && !hit;

    // ~~~~~~~~~~~~~~~~~~~~
    // Routing.
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // Address and payload pass through unchanged.
        ram_req = flat_req;
        // A miss never reaches the RAM.
        if (miss) begin
            ram_req.ren = 1'b0;
            ram_req.wen = 1'b0;
        end
    end

    always_comb begin
        if (miss) begin
            // Completes in the same cycle with an error.
            flat_rsp.busy  = 1'b0;
            flat_rsp.error = 1'b1;
            flat_rsp.rdata = '0;
        end else begin
            // Hits and idle cycles see the RAM response.
            flat_rsp = ram_rsp;
        end
    end

endmodule

`default_nettype wire

/* hdl/bus_bridge_top.sv */
// Top level of the bus bridge subsystem.
// Chains bridge, address decode and wait-state RAM.

`timescale 1ns/1ps
`default_nettype none

module bus_bridge_top #(
    parameter int RAM_WORDS   = 256,
    parameter int WAIT_CYCLES = 2
) (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t pipe_req,
    output bus_pkg::bus_rsp_t pipe_rsp
);

    import bus_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage links.
    // ~~~~~~~~~~~~~~~~~~~~

    // Bridge to decode.
    bus_req_t flat_req;
    bus_rsp_t flat_rsp;

    // Decode to RAM.
    bus_req_t ram_req;
    bus_rsp_t ram_rsp;

    // Registers requests and holds them while busy.
    bus_nonpipeline u_bridge (
        .CLK      (CLK),
        .nRST     (nRST),
        .pipe_req (pipe_req),
        .pipe_rsp (pipe_rsp),
        .flat_req (flat_req),
        .flat_rsp (flat_rsp)
    );

    // Window check, misses end here.
    bus_addr_decode #(
        .RAM_WORDS (RAM_WORDS)
    ) u_decode (
        .flat_req (flat_req),
        .flat_rsp (flat_rsp),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    // Storage with wait states.
    wait_ram #(
        .RAM_WORDS   (RAM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_ram (
        .CLK     (CLK),
        .nRST    (nRST),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

endmodule

`default_nettype wire

/* hdl/bus_nonpipeline.sv */
// Bridge stage from the pipelined bus to the flat bus.
// Registers each request and holds it while the slave is busy.

`timescale 1ns/1ps
`default_nettype none

module bus_nonpipeline (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t pipe_req,
    output bus_pkg::bus_rsp_t pipe_rsp,
    output bus_pkg::bus_req_t flat_req,
    input  bus_pkg::bus_rsp_t flat_rsp
);

    import bus_pkg::*;

    // Registered request on the flat side.
    bus_req_t req_q;

    // Registered request carries no strobe.
    logic req_idle;
    // Slave can take a new request at the next edge.
    logic load_en;
    // Registered address sits at the idle address.
    logic idle_addr;

    // ~~~~~~~~~~~~~~~~~~~~
    // Request register.
    // ~~~~~~~~~~~~~~~~~~~~

    assign req_idle = !req_q.ren && !req_q.wen;

    // Load when the slave finishes or has nothing to do.
    assign load_en = !flat_rsp.busy || req_idle;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // Register follows the requester even in reset.
            req_q <= pipe_req;
        end else if (load_en) begin
            req_q <= pipe_req;
        end
        // Otherwise hold, the slave still works on it.
    end

    assign flat_req = req_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Upstream response.
    // ~~~~~~~~~~~~~~~~~~~~

    // Address zero is reserved as idle.
    assign idle_addr = (req_q.addr == '0);

    always_comb begin
        // Busy while idle address sits in the register, else slave busy.
        pipe_rsp.busy  = idle_addr ? 1'b1 : flat_rsp.busy;
        // Read data and error go straight back.
        pipe_rsp.error = flat_rsp.error;
        pipe_rsp.rdata = flat_rsp.rdata;
    end

endmodule

`default_nettype wire

/* tb/bus_bridge_chk.sv */
// Bound checker for the bus bridge subsystem.
// Watches the flat bus and the upstream response of the top level.

`timescale 1ns/1ps
`default_nettype none

module bus_bridge_chk #(
    parameter int WAIT_CYCLES = 2
) (
    input logic              CLK,
    input logic              nRST,
    input bus_pkg::bus_rsp_t pipe_rsp,
    input bus_pkg::bus_req_t flat_req,
    input bus_pkg::bus_rsp_t flat_rsp
);

    // Longest busy stretch in cycles and never below one.
    localparam int MAX_BUSY = (WAIT_CYCLES > 0) ? WAIT_CYCLES : 1;

    // Count of failed assertions that the testbench reads.
    int assert_errs = 0;

    // Flat request carries a strobe.
    logic req_active;

    assign req_active = flat_req.ren || flat_req.wen;

    // ~~~~~~~~~~~~~~~~~~~~
    // Slave timing.
    // ~~~~~~~~~~~~~~~~~~~~

    // Busy drops within the wait-state budget.
    a_busy_bounded: assert property (
        @(posedge CLK) disable iff (!nRST)
        $rose(flat_rsp.busy) |-> ##[1:MAX_BUSY] !flat_rsp.busy
    ) else begin
        assert_errs++;
        $error("slave busy held longer than %0d cycles", WAIT_CYCLES);
    end

    // The bridge holds its request while the slave works on it.
    a_req_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (flat_rsp.busy && req_active) |=> $stable(flat_req)
    ) else begin
        assert_errs++;
        $error("flat request changed while the slave was busy");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Upstream response.
    // ~~~~~~~~~~~~~~~~~~~~

    // An error only ever ends an access.
    a_err_not_busy: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(pipe_rsp.error && pipe_rsp.busy)
    ) else begin
        assert_errs++;
        $error("error flag raised together with busy");
    end

endmodule

`default_nettype wire

/* tb/bus_bridge_tb.sv */
// Testbench for the bus bridge subsystem.
// Drives the pipelined side and checks data, error and latency against a shadow RAM.

`timescale 1ns/1ps
`default_nettype none

module bus_bridge_tb;

    import bus_pkg::*;

    localparam int RAM_WORDS   = 256;
    localparam int WAIT_CYCLES = 2;
    localparam int PERIOD_NS   = 100;
    localparam int RST_CYCLES  = 8;
    // Inputs change this long after the rising edge.
    localparam int DRIVE_DLY   = 10;
    // Up to 600 accesses at WAIT_CYCLES + 3 cycles each, plus reset.
    localparam int TIMEOUT_CYCLES = 600 * (WAIT_CYCLES + 3) + RST_CYCLES;
    localparam logic [31:0] LCG_SEED = 32'h4f3df4c6;
    // Words hit by the random write test.
    localparam int RND_WORDS = 64;
    // Both strobes low, address zero.
    localparam bus_req_t IDLE_REQ = '0;

    logic     CLK;
    logic     nRST;
    bus_req_t pipe_req;
    bus_rsp_t pipe_rsp;

    // Shadow RAM with a valid bit per byte.
    logic [DATA_W-1:0] shadow    [RAM_WORDS];
    logic [BE_W-1:0]   shadow_bv [RAM_WORDS];

    // Requests for the next run, then completed accesses waiting for the checker.
    bus_req_t seq_q[$];
    bus_req_t chk_req_q[$];
    bus_rsp_t chk_rsp_q[$];
    int       chk_lat_q[$];

    int data_errs = 0;
    int flag_errs = 0;
    int lat_errs  = 0;
    int checked   = 0;
    int cycle_cnt = 0;

    logic [31:0] lcg_state = LCG_SEED;

    tb_clock_gen #(
        .PERIOD_NS  (PERIOD_NS),
        .RST_CYCLES (RST_CYCLES),
        .RST_DLY_NS (DRIVE_DLY)
    ) u_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    bus_bridge_top #(
        .RAM_WORDS   (RAM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) DUT (
        .CLK      (CLK),
        .nRST     (nRST),
        .pipe_req (pipe_req),
        .pipe_rsp (pipe_rsp)
    );

    // Checker on the flat bus and the upstream response.
    bind bus_bridge_top bus_bridge_chk #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_chk (
        .CLK      (CLK),
        .nRST     (nRST),
        .pipe_rsp (pipe_rsp),
        .flat_req (flat_req),
        .flat_rsp (flat_rsp)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~

    // Numerical Recipes constants.
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input int idx);
        return RAM_BASE + ADDR_W'(4 * idx);
    endfunction

    // Aligned and below the end of the window.
    function automatic logic in_window(input logic [ADDR_W-1:0] addr);
        return (addr >= RAM_BASE)
            && (addr < RAM_BASE + ADDR_W'(BE_W * RAM_WORDS))
            && (addr[1:0] == 2'b00);
    endfunction

    // Edges from the load edge to the completing edge with both counted.
    function automatic int expected_edges(input bus_req_t req);
        return in_window(req.addr) ? WAIT_CYCLES + 2 : 2;
    endfunction

    // Expected response; applies writes to the shadow.
    function automatic bus_rsp_t ref_model(input bus_req_t req, output logic known);
        bus_rsp_t exp;
        int       idx;
        exp   = '0;
        known = 1'b0;
        if (!in_window(req.addr)) begin
            // Blocked request leaves the RAM untouched and returns zero data.
            exp.error = 1'b1;
            known     = 1'b1;
        end else begin
            idx = int'((req.addr - RAM_BASE) >> 2);
            if (req.ren) begin
                exp.rdata = shadow[idx];
                known     = &shadow_bv[idx];
            end
            if (req.wen) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (req.byte_en[b]) begin
                        shadow[idx][8*b +: 8] = req.wdata[8*b +: 8];
                        shadow_bv[idx][b]     = 1'b1;
                    end
                end
            end
        end
        return exp;
    endfunction

    function automatic bus_req_t make_write(input logic [ADDR_W-1:0] addr,
                                            input logic [BE_W-1:0]   be,
                                            input logic [DATA_W-1:0] data);
        bus_req_t r;
        r         = '0;
        r.wen     = 1'b1;
        r.addr    = addr;
        r.byte_en = be;
        r.wdata   = data;
        return r;
    endfunction

    function automatic bus_req_t make_read(input logic [ADDR_W-1:0] addr);
        bus_req_t r;
        r         = '0;
        r.ren     = 1'b1;
        r.addr    = addr;
        r.byte_en = '1;
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic compare_rsp_data(input bus_rsp_t got, input bus_rsp_t exp,
                                    input bus_req_t req);
        if (got.rdata !== exp.rdata) begin
            data_errs++;
            $display("error at %0t ns: addr %h rdata %h, expected %h",
                     $time, req.addr, got.rdata, exp.rdata);
        end
    endtask

    task automatic compare_rsp_error(input bus_rsp_t got, input bus_rsp_t exp,
                                     input bus_req_t req);
        if (got.error !== exp.error) begin
            flag_errs++;
            $display("error at %0t ns: addr %h error flag %b, expected %b",
                     $time, req.addr, got.error, exp.error);
        end
    endtask

    task automatic compare_latency(input int got, input int exp, input bus_req_t req);
        if (got != exp) begin
            lat_errs++;
            $display("error at %0t ns: addr %h completed after %0d edges, expected %0d",
                     $time, req.addr, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Requester.
    // ~~~~~~~~~~~~~~~~~~~~

    // Runs seq_q back to back; starts and ends at a drive point with an idle register.
    task automatic run_seq();
        bus_rsp_t rsp;
        int       edges;
        logic     done;
        pipe_req = seq_q[0];
        @(posedge CLK);
        for (int i = 0; i < seq_q.size(); i++) begin
            #(DRIVE_DLY);
            // Next request waits on the bus until this one completes.
            if (i + 1 < seq_q.size()) begin
                pipe_req = seq_q[i + 1];
            end else begin
                pipe_req = IDLE_REQ;
            end
            edges = 1;
            done  = 1'b0;
            while (!done) begin
                // Response is settled mid-cycle.
                @(negedge CLK);
                rsp = pipe_rsp;
                @(posedge CLK);
                edges++;
                done = (rsp.busy === 1'b0);
            end
            chk_req_q.push_back(seq_q[i]);
            chk_rsp_q.push_back(rsp);
            chk_lat_q.push_back(edges);
        end
        #(DRIVE_DLY);
    endtask

    task automatic run_single(input bus_req_t req);
        seq_q.delete();
        seq_q.push_back(req);
        run_seq();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Processes.
    // ~~~~~~~~~~~~~~~~~~~~

    // Checks completed accesses in issue order.
    initial begin : compare_proc
        bus_req_t req;
        bus_rsp_t got;
        bus_rsp_t exp;
        int       edges;
        logic     known;
        forever begin
            wait (chk_req_q.size() != 0);
            req   = chk_req_q.pop_front();
            got   = chk_rsp_q.pop_front();
            edges = chk_lat_q.pop_front();
            exp   = ref_model(req, known);
            compare_rsp_error(got, exp, req);
            if (known) begin
                compare_rsp_data(got, exp, req);
            end
            compare_latency(edges, expected_edges(req), req);
            checked++;
        end
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("run hung, no end after %0d clock cycles", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]       rnd;
        logic [ADDR_W-1:0] addr;
        int                total;
        pipe_req = IDLE_REQ;
        for (int i = 0; i < RAM_WORDS; i++) begin
            shadow_bv[i] = '0;
        end
        wait (nRST === 1'b1);
        @(posedge CLK);
        #(DRIVE_DLY);

        // Full word write, then read it back.
        run_single(make_write(word_addr(252), '1, 32'hA5C3_5A3C));
        run_single(make_read(word_addr(252)));

        // Seed the random region with full words.
        for (int i = 0; i < RND_WORDS; i++) begin
            run_single(make_write(word_addr(i), '1, lcg_next()));
        end
        // Random partial writes, then read every word.
        for (int i = 0; i < 200; i++) begin
            rnd = lcg_next();
            run_single(make_write(word_addr(int'(rnd[21:16])), rnd[27:24], lcg_next()));
        end
        for (int i = 0; i < RND_WORDS; i++) begin
            run_single(make_read(word_addr(i)));
        end

        // Misaligned and out-of-window accesses. A leak would land in words 8 and 0.
        addr = word_addr(8);
        run_single(make_write(addr, '1, 32'h1234_5678));
        run_single(make_write(addr + 2, '1, 32'hDEAD_BEEF));
        run_single(make_read(addr + 1));
        run_single(make_write(RAM_BASE + ADDR_W'(BE_W * RAM_WORDS), '1, 32'hDEAD_BEEF));
        run_single(make_read(32'h0000_0800));
        run_single(make_read(addr));
        run_single(make_read(word_addr(0)));

        // Latency of single hits and misses.
        run_single(make_write(word_addr(200), '1, lcg_next()));
        run_single(make_read(word_addr(200)));
        run_single(make_read(32'h0000_2000));
        run_single(make_write(word_addr(200) + 3, 4'h1, 32'h0));

        // Back-to-back writes followed by back-to-back reads.
        seq_q.delete();
        for (int i = 0; i < 16; i++) begin
            seq_q.push_back(make_write(word_addr(128 + i), '1, lcg_next()));
        end
        for (int i = 0; i < 16; i++) begin
            seq_q.push_back(make_read(word_addr(128 + i)));
        end
        run_seq();

        // Back-to-back partial writes interleaved with reads and one miss.
        seq_q.delete();
        for (int i = 0; i < 8; i++) begin
            rnd = lcg_next();
            seq_q.push_back(make_write(word_addr(128 + i), rnd[27:24], lcg_next()));
            seq_q.push_back(make_read(word_addr(128 + i)));
            if (i == 3) begin
                seq_q.push_back(make_write(32'h0000_0F00, '1, 32'hFFFF_FFFF));
            end
        end
        run_seq();

        // Let the checker drain.
        wait (chk_req_q.size() == 0);
        #(DRIVE_DLY);
        total = data_errs + flag_errs + lat_errs + DUT.u_chk.assert_errs;
        $display("%0d accesses checked, errors: data %0d, flag %0d, latency %0d, assert %0d",
                 checked, data_errs, flag_errs, lat_errs, DUT.u_chk.assert_errs);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Clock and reset source for the bus bridge testbench.
// Free-running clock, active-low reset held for a fixed number of cycles.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8,
    parameter int RST_DLY_NS = 10
) (
    output logic CLK,
    output logic nRST
);

    // Square wave, low at time zero.
    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // Release reset shortly after a rising edge, away from the sampling point.
    initial begin
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        #(RST_DLY_NS);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/bus_pkg.sv
hdl/bus_nonpipeline.sv
hdl/bus_addr_decode.sv
wait_ram/wait_ram.sv
hdl/bus_bridge_top.sv
tb/tb_clock_gen.sv
tb/bus_bridge_chk.sv
tb/bus_bridge_tb.sv

/* wait_ram/wait_ram.sv */
// Word RAM with byte enables and a configurable number of wait states.
// Every access holds busy for WAIT_CYCLES cycles, then completes.

`timescale 1ns/1ps
`default_nettype none

module wait_ram #(
    parameter int RAM_WORDS   = 256,
    parameter int WAIT_CYCLES = 2
) (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::bus_req_t ram_req,
    output bus_pkg::bus_rsp_t ram_rsp
);

    import bus_pkg::*;

    // Word index width, at least one bit.
    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    // Wait counter width, at least one bit.
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
    // Count at which the access completes.
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(WAIT_CYCLES);

    // ~~~~~~~~~~~~~~~~~~~~
    // Storage.
    // ~~~~~~~~~~~~~~~~~~~~

    // Word array, contents undefined after reset.
    logic [DATA_W-1:0] mem [RAM_WORDS];

    // Byte offset from the window base.
    logic [ADDR_W-1:0] byte_off;
    // Word selected by the request.
    logic [IDX_W-1:0]  word_idx;

    // ~~~~~~~~~~~~~~~~~~~~
    // Access control.
    // ~~~~~~~~~~~~~~~~~~~~

    // Cycles spent on the current request.
    logic [CNT_W-1:0] wait_cnt;
    // Request has a strobe set.
    logic active;
    // Still counting wait states.
    logic busy;
    // Last cycle of the access.
    logic done;
    // Write commits at the end of this cycle.
    logic wr_commit;
    // Read data is returned in this cycle.
    logic rd_done;

    assign byte_off = ram_req.addr - RAM_BASE;
    // Drop the byte lane bits.
    assign word_idx = byte_off[IDX_W+1:2];

    assign active = ram_req.ren || ram_req.wen;

    // Busy until the count reaches the wait setting.
    assign busy = active && (wait_cnt < CNT_DONE);
    assign done = active && !busy;

    assign wr_commit = done && ram_req.wen;
    assign rd_done   = done && ram_req.ren;

    // Counts up while busy.
    // Clears on the completing edge so the next request starts at zero.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Write port.
    // ~~~~~~~~~~~~~~~~~~~~

    // Only the enabled bytes change.
    always_ff @(posedge CLK) begin
        if (wr_commit) begin
            for (int i = 0; i < BE_W; i++) begin
                if (ram_req.byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Response.
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ram_rsp.busy  = busy;
        // This slave never signals an error.
        ram_rsp.error = 1'b0;
        // Word shows only in the completing read cycle.
        ram_rsp.rdata = rd_done ? mem[word_idx] : '0;
    end

endmodule

`default_nettype wire
